// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = etm_mul_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = SOME TESTS FAILED
PASS_MSG  = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation stopped before reporting a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
logic/etm_pkg.sv
logic/etm_wb_regs.sv
logic/etm_operand_split.sv
logic/etm_partial_products.sv
logic/etm_sum_select.sv
logic/etm_result_fifo.sv
logic/etm_mul_top.sv
verif/etm_mul_tb.sv

// ==== logic/etm_mul_top.sv ====
// 16-bit unsigned etm multiplier on a classic wishbone slave; SPLIT in 0..16
`timescale 1ns/1ps

module etm_mul_top #(
   parameter int SPLIT      = 8,  // low bits handled approximately
   parameter int FIFO_DEPTH = 4   // result queue entries
) (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        wb_cyc,
   input  logic        wb_stb,
   input  logic        wb_we,
   input  logic [3:0]  wb_adr,
   input  logic [31:0] wb_dat_w,
   input  logic [3:0]  wb_sel,
   output logic [31:0] wb_dat_r,
   output logic        wb_ack
);
   import etm_pkg::*;

   localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

   op_t               op;          // launched operation
   split_t            split;       // stage 1
   pp_t               pp;          // stage 2
   logic              res_valid;   // stage 3, push strobe
   logic [prod_w-1:0] res;
   logic [prod_w-1:0] fifo_head;
   logic [cnt_w-1:0]  fifo_count;
   logic              fifo_pop;

   etm_wb_regs #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) regs_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_we       (wb_we),
      .wb_adr      (wb_adr),
      .wb_dat_w    (wb_dat_w),
      .wb_sel      (wb_sel),
      .fifo_head   (fifo_head),
      .fifo_count  (fifo_count),
      .stage_valid ({res_valid, pp.valid, split.valid}),  // all ops not yet queued
      .wb_dat_r    (wb_dat_r),
      .wb_ack      (wb_ack),
      .op          (op),
      .fifo_pop    (fifo_pop)
   );

   etm_operand_split #(.SPLIT(SPLIT)) split_i (
      .clk    (clk),
      .arst_n (arst_n),
      .op     (op),
      .split  (split)
   );

   etm_partial_products #(.SPLIT(SPLIT)) pp_i (
      .clk    (clk),
      .arst_n (arst_n),
      .split  (split),
      .pp     (pp)
   );

   etm_sum_select sum_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .pp        (pp),
      .res_valid (res_valid),
      .res       (res)
   );

   etm_result_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .push      (res_valid),
      .push_data (res),
      .pop       (fifo_pop),
      .head      (fifo_head),
      .count     (fifo_count)
   );

endmodule

// ==== logic/etm_operand_split.sv ====
// SPLIT must lie in 0..op_w; halves are right aligned in full width fields
`timescale 1ns/1ps

module etm_operand_split #(
   parameter int SPLIT = 8
) (
   input  logic             clk,
   input  logic             arst_n,
   input  etm_pkg::op_t     op,
   output etm_pkg::split_t  split
);
   import etm_pkg::*;

   localparam logic [op_w-1:0] lo_mask = {op_w{1'b1}} >> (op_w - SPLIT);

   logic [op_w-1:0] x_lo;
   logic [op_w-1:0] y_lo;
   logic [op_w-1:0] x_hi;
   logic [op_w-1:0] y_hi;

   assign x_lo = op.x & lo_mask;  // bits below SPLIT
   assign y_lo = op.y & lo_mask;
   assign x_hi = op.x >> SPLIT;   // bits at and above SPLIT
   assign y_hi = op.y >> SPLIT;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         split <= '0;
      end else begin
         split.valid <= op.valid;
         if (op.valid) begin
            split.approx <= op.approx;
            // precise multipliers see nothing in approx mode
            split.x_lo_p <= op.approx ? '0 : x_lo;
            split.y_lo_p <= op.approx ? '0 : y_lo;
            split.x_hi_p <= op.approx ? '0 : x_hi;
            split.y_hi_p <= op.approx ? '0 : y_hi;
            split.x_hi   <= x_hi;                   // hi*hi used in both modes
            split.y_hi   <= y_hi;
            split.x_lo_a <= op.approx ? x_lo : '0;  // etm part idle when precise
            split.y_lo_a <= op.approx ? y_lo : '0;
         end
      end
   end

   // the two low paths are mutually exclusive
   a_lo_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
      split.valid |-> !(((split.x_lo_p | split.y_lo_p) != '0) &&
                        ((split.x_lo_a | split.y_lo_a) != '0)))
      else $error("precise and approx low fields both active");

endmodule

// ==== logic/etm_partial_products.sv ====
// products are unsigned; SPLIT in 0..op_w so every shifted term fits prod_w
`timescale 1ns/1ps

module etm_partial_products #(
   parameter int SPLIT = 8
) (
   input  logic             clk,
   input  logic             arst_n,
   input  etm_pkg::split_t  split,
   output etm_pkg::pp_t     pp
);
   import etm_pkg::*;

   logic [op_w-1:0]   etm_r;      // or/saturate result of the low halves
   logic [prod_w-1:0] p_00;
   logic [prod_w-1:0] p_01;
   logic [prod_w-1:0] p_10;
   logic [prod_w-1:0] p_11;

   // scan from the top low bit down, or each pair
   // first 1/1 pair forces that bit and all below to 1
   function automatic logic [op_w-1:0] etm_low(input logic [op_w-1:0] a,
                                               input logic [op_w-1:0] b);
      logic [op_w-1:0] r;
      logic            sat;
      r   = '0;
      sat = 1'b0;
      for (int i = SPLIT - 1; i >= 0; i--) begin
         if (sat || (a[i] && b[i])) begin
            r[i] = 1'b1;
            sat  = 1'b1;
         end else begin
            r[i] = a[i] | b[i];
         end
      end
      return r;
   endfunction

   assign etm_r = etm_low(split.x_lo_a, split.y_lo_a);  // zero inputs when precise

   // widen before multiply so no bits are lost
   assign p_00 = prod_w'(split.x_lo_p) * prod_w'(split.y_lo_p);
   assign p_01 = prod_w'(split.x_lo_p) * prod_w'(split.y_hi_p);
   assign p_10 = prod_w'(split.x_hi_p) * prod_w'(split.y_lo_p);
   assign p_11 = prod_w'(split.x_hi) * prod_w'(split.y_hi);  // ungated

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pp <= '0;
      end else begin
         pp.valid <= split.valid;
         if (split.valid) begin
            pp.approx <= split.approx;
            pp.pp_00  <= p_00;
            pp.pp_01  <= p_01 << SPLIT;
            pp.pp_10  <= p_10 << SPLIT;
            pp.pp_11  <= p_11 << (2 * SPLIT);
            pp.etm_lo <= prod_w'(etm_r) << SPLIT;
         end
      end
   end

   // gating in stage 1 keeps the etm field clear in precise mode
   a_precise_no_etm: assert property (@(posedge clk) disable iff (!arst_n)
      (pp.valid && !pp.approx) |-> (pp.etm_lo == '0))
      else $error("etm_lo nonzero in precise mode");

endmodule

// ==== logic/etm_pkg.sv ====
// operand width is fixed at 16 bits; stage fields are full width, right aligned, unused bits zero
package etm_pkg;

   localparam int op_w   = 16;        // unsigned operand bits
   localparam int prod_w = 2 * op_w;  // full product, one bus word

   // byte offsets on wb_adr
   localparam logic [3:0] addr_operands = 4'h0;  // x low half, y high half
   localparam logic [3:0] addr_ctrl     = 4'h4;  // bit 0 approx
   localparam logic [3:0] addr_result   = 4'h8;  // read pops fifo
   localparam logic [3:0] addr_status   = 4'hc;  // count, empty, full, in flight

   // one launched multiplication
   typedef struct packed {
      logic            valid;
      logic            approx;  // mode latched at write time
      logic [op_w-1:0] x;
      logic [op_w-1:0] y;
   } op_t;

   // stage 1 output, halves gated per mode
   typedef struct packed {
      logic            valid;
      logic            approx;
      logic [op_w-1:0] x_lo_p;  // zero in approx mode
      logic [op_w-1:0] y_lo_p;
      logic [op_w-1:0] x_hi_p;  // zero in approx mode
      logic [op_w-1:0] y_hi_p;
      logic [op_w-1:0] x_hi;    // never gated, feeds hi*hi
      logic [op_w-1:0] y_hi;
      logic [op_w-1:0] x_lo_a;  // zero in precise mode
      logic [op_w-1:0] y_lo_a;
   } split_t;

   // stage 2 output, every term already shifted into place
   typedef struct packed {
      logic              valid;
      logic              approx;
      logic [prod_w-1:0] pp_00;
      logic [prod_w-1:0] pp_01;
      logic [prod_w-1:0] pp_10;
      logic [prod_w-1:0] pp_11;
      logic [prod_w-1:0] etm_lo;  // or/saturate field of the low halves
   } pp_t;

endpackage

// ==== logic/etm_result_fifo.sv ====
// FIFO_DEPTH must be 2 or more; head is undefined while empty
`timescale 1ns/1ps

module etm_result_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                             clk,
   input  logic                             arst_n,
   input  logic                             push,
   input  logic [etm_pkg::prod_w-1:0]       push_data,
   input  logic                             pop,
   output logic [etm_pkg::prod_w-1:0]       head,
   output logic [$clog2(FIFO_DEPTH+1)-1:0]  count
);
   import etm_pkg::*;

   localparam int ptr_w = $clog2(FIFO_DEPTH);
   localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

   logic [prod_w-1:0] mem [FIFO_DEPTH];
   logic [ptr_w-1:0]  wr_ptr;
   logic [ptr_w-1:0]  rd_ptr;
   logic              full;
   logic              empty;
   logic              do_push;
   logic              do_pop;

   // wrap by compare, depth need not be a power of two
   function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
      return (p == ptr_w'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign full    = (count == cnt_w'(FIFO_DEPTH));
   assign empty   = (count == '0);
   assign do_push = push & ~full;   // back-pressure upstream keeps this from dropping
   assign do_pop  = pop & ~empty;
   assign head    = mem[rd_ptr];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= ptr_next(wr_ptr);
         if (do_pop)  rd_ptr <= ptr_next(rd_ptr);
         count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
      end
   end

   always_ff @(posedge clk) begin
      if (do_push)
         mem[wr_ptr] <= push_data;
   end

   a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
      push |-> !full)
      else $error("result push while fifo full");

   a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
      pop |-> !empty)
      else $error("result pop while fifo empty");

endmodule

// ==== logic/etm_sum_select.sv ====
// result is registered; approx terms occupy disjoint bit ranges
`timescale 1ns/1ps

module etm_sum_select (
   input  logic                       clk,
   input  logic                       arst_n,
   input  etm_pkg::pp_t               pp,
   output logic                       res_valid,
   output logic [etm_pkg::prod_w-1:0] res
);
   import etm_pkg::*;

   logic [prod_w-1:0] sum_precise;
   logic [prod_w-1:0] sum_approx;

   // gated terms are zero in approx mode, so only the precise sum uses them
   assign sum_precise = pp.pp_00 + pp.pp_01 + pp.pp_10 + pp.pp_11;

   // pp_11 starts at 2*SPLIT, etm_lo ends below it
   assign sum_approx = pp.pp_11 | pp.etm_lo;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         res_valid <= 1'b0;
      else
         res_valid <= pp.valid;  // push strobe to fifo
   end

   always_ff @(posedge clk) begin
      if (pp.valid)
         res <= pp.approx ? sum_approx : sum_precise;
   end

   // no carries between the two approx terms
   a_approx_disjoint: assert property (@(posedge clk) disable iff (!arst_n)
      (pp.valid && pp.approx) |-> ((pp.pp_11 & pp.etm_lo) == '0))
      else $error("approx terms overlap");

endmodule

// ==== logic/etm_wb_regs.sv ====
// classic wishbone only, no bursts or err; unselected operand bytes are taken as zero
`timescale 1ns/1ps

module etm_wb_regs #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                                clk,
   input  logic                                arst_n,
   input  logic                                wb_cyc,
   input  logic                                wb_stb,
   input  logic                                wb_we,
   input  logic [3:0]                          wb_adr,
   input  logic [31:0]                         wb_dat_w,
   input  logic [3:0]                          wb_sel,
   input  logic [etm_pkg::prod_w-1:0]          fifo_head,
   input  logic [$clog2(FIFO_DEPTH+1)-1:0]     fifo_count,
   input  logic [2:0]                          stage_valid,
   output logic [31:0]                         wb_dat_r,
   output logic                                wb_ack,
   output etm_pkg::op_t                        op,
   output logic                                fifo_pop
);
   import etm_pkg::*;

   localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

   logic        req;          // access not yet acked
   logic        is_opnd_wr;
   logic        is_ctrl_wr;
   logic        is_res_rd;
   logic        room;         // fifo plus pipeline can take one more
   logic        accept;
   logic        launch;
   logic        fifo_empty;
   logic        fifo_full;
   logic        ctrl_approx;
   logic [2:0]  in_flight;
   logic [31:0] wr_data;      // byte-masked write word
   logic [31:0] rd_data;

   assign req        = wb_cyc & wb_stb & ~wb_ack;  // ack drops before next access
   assign is_opnd_wr = wb_we & (wb_adr == addr_operands);
   assign is_ctrl_wr = wb_we & (wb_adr == addr_ctrl);
   assign is_res_rd  = ~wb_we & (wb_adr == addr_result);
   assign wr_data    = wb_dat_w & {{8{wb_sel[3]}}, {8{wb_sel[2]}}, {8{wb_sel[1]}}, {8{wb_sel[0]}}};
   assign fifo_empty = (fifo_count == '0);
   assign fifo_full  = (fifo_count == cnt_w'(FIFO_DEPTH));

   // op register counts too, it pushes three stages later
   assign in_flight = 3'(op.valid) + 3'(stage_valid[0]) + 3'(stage_valid[1])
                    + 3'(stage_valid[2]);
   assign room      = (int'(fifo_count) + int'(in_flight)) < FIFO_DEPTH;
   assign accept    = req & (~is_opnd_wr | room);  // only operand writes stall
   assign launch    = req & is_opnd_wr & room;

   always_comb begin
      rd_data = '0;
      case (wb_adr)
         addr_ctrl:   rd_data[0] = ctrl_approx;
         addr_result: if (!fifo_empty) rd_data = fifo_head;  // zero when empty
         addr_status: rd_data[8:0] = {in_flight, fifo_full, fifo_empty, 4'(fifo_count)};
         default:     rd_data = '0;  // operands is write only
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_ack      <= 1'b0;
         fifo_pop    <= 1'b0;
         ctrl_approx <= 1'b0;  // precise after reset
         op          <= '0;
      end else begin
         wb_ack   <= accept;
         fifo_pop <= accept & is_res_rd & ~fifo_empty;  // pops in the ack cycle
         op.valid <= launch;
         if (launch) begin
            op.approx <= ctrl_approx;  // mode in force at write time
            op.x      <= wr_data[15:0];
            op.y      <= wr_data[31:16];
         end
         if (accept && is_ctrl_wr && wb_sel[0])
            ctrl_approx <= wr_data[0];
      end
   end

   // head is stable until this access pops it
   always_ff @(posedge clk) begin
      if (accept)
         wb_dat_r <= rd_data;
   end

   a_ack_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
      wb_ack |=> !wb_ack)
      else $error("wb_ack held for two cycles");

   a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
      fifo_pop |-> (fifo_count != '0))
      else $error("result pop issued while fifo empty");

endmodule

// ==== verif/etm_mul_tb.sv ====
// single wishbone master doing one transfer at a time; SPLIT and FIFO_DEPTH here set the dut instance
`timescale 1ns/1ps

module etm_mul_tb;

   localparam int SPLIT      = 8;
   localparam int FIFO_DEPTH = 4;
   localparam int n_rand     = 200;                    // random pairs per mode
   localparam int n_ops      = 2 * n_rand + 11;        // plus corners, mode switch, back-pressure
   localparam int wd_ns      = n_ops * 40 * 4 + 2000;  // watchdog limit with margin

   localparam logic [3:0] reg_operands = 4'h0;
   localparam logic [3:0] reg_ctrl     = 4'h4;
   localparam logic [3:0] reg_result   = 4'h8;
   localparam logic [3:0] reg_status   = 4'hc;

   logic        clk;
   logic        arst_n;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [3:0]  wb_adr;
   logic [31:0] wb_dat_w;
   logic [3:0]  wb_sel;
   logic [31:0] wb_dat_r;
   logic        wb_ack;
   int          errors;

   etm_mul_top #(
      .SPLIT      (SPLIT),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) dut_i (
      .clk      (clk),
      .arst_n   (arst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_sel   (wb_sel),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack)
   );

   always #2 clk = ~clk;  // 4 ns period

   // expected product in precise or etm mode
   function automatic logic [31:0] ref_product(input logic [15:0] x, input logic [15:0] y,
                                               input logic approx);
      logic [15:0] xh;
      logic [15:0] yh;
      logic [15:0] xl;
      logic [15:0] yl;
      logic [15:0] r;
      int          top_both;
      if (!approx)
         return 32'(x) * 32'(y);
      xh = x >> SPLIT;
      yh = y >> SPLIT;
      xl = x - (xh << SPLIT);  // bits below SPLIT
      yl = y - (yh << SPLIT);
      top_both = -1;
      for (int i = 0; i < SPLIT; i++)
         if (xl[i] && yl[i]) top_both = i;  // ends on the highest 1/1 pair
      r = xl | yl;
      if (top_both >= 0)
         r = r | 16'((32'h1 << (top_both + 1)) - 1);  // saturate from there down
      return ((32'(xh) * 32'(yh)) << (2 * SPLIT)) + (32'(r) << SPLIT);
   endfunction

   task automatic check_hex(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      assert (got == exp)
      else begin
         errors++;
         $display("ERROR %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      assert (cond)
      else begin
         errors++;
         $display("failure: %s", what);
      end
   endtask

   // one classic transfer that gives up after max_cycles without ack
   task automatic wb_cycle(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, input int max_cycles,
                           output logic acked, output logic [31:0] rd);
      int n;
      n     = 0;
      acked = 1'b0;
      rd    = '0;
      @(posedge clk);
      #1;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = dat;
      wb_sel   = sel;
      while (!acked && n < max_cycles) begin
         @(posedge clk);
         #1;
         n++;
         if (wb_ack) begin
            acked = 1'b1;
            rd    = wb_dat_r;  // registered so stable through the ack cycle
         end
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
      logic        acked;
      logic [31:0] rd;
      wb_cycle(1'b1, adr, dat, 4'hf, 50, acked, rd);
      check_true(acked, "write got no ack within 50 cycles");
   endtask

   task automatic wb_read(input logic [3:0] adr, output logic [31:0] rd);
      logic acked;
      wb_cycle(1'b0, adr, 32'h0, 4'hf, 50, acked, rd);
      check_true(acked, "read got no ack within 50 cycles");
   endtask

   // poll STATUS until the fifo holds at least n results
   task automatic wait_count(input int n);
      logic [31:0] st;
      int          polls;
      polls = 0;
      st    = '0;
      while (int'(st[3:0]) < n && polls < 50) begin
         wb_read(reg_status, st);
         polls++;
      end
      check_true(int'(st[3:0]) >= n, "result count never reached the expected level");
   endtask

   task automatic run_op(input logic [15:0] x, input logic [15:0] y, input logic approx);
      logic [31:0] got;
      wb_write(reg_operands, {y, x});
      wait_count(1);
      wb_read(reg_result, got);
      check_hex("wb_dat_r result", got, ref_product(x, y, approx));
   endtask

   ack_single: assert property (@(posedge clk) disable iff (!arst_n) wb_ack |=> !wb_ack)
      else begin
         errors++;
         $display("wb_ack stayed high for more than one cycle");
      end

   ack_after_stb: assert property (@(posedge clk) disable iff (!arst_n)
      wb_ack |-> $past(wb_cyc && wb_stb))
      else begin
         errors++;
         $display("wb_ack rose without a strobe in the cycle before");
      end

   count_bound: assert property (@(posedge clk) disable iff (!arst_n)
      int'(dut_i.fifo_count) <= FIFO_DEPTH)
      else begin
         errors++;
         $display("result count went above the fifo depth");
      end

   initial begin
      #(wd_ns);
      $display("watchdog expired, the run did not finish in time");
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      logic [31:0] rd;
      logic        acked;
      logic [15:0] x;
      logic [15:0] y;
      logic [31:0] exp_q[$];
      void'($urandom(49704));
      errors   = 0;
      clk      = 1'b0;
      arst_n   = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      wb_sel   = '0;
      repeat (10) @(posedge clk);
      #1 arst_n = 1'b1;

      wb_read(reg_status, rd);
      check_hex("wb_dat_r status", rd, 32'h0000_0010);  // only empty set
      wb_read(reg_ctrl, rd);
      check_hex("wb_dat_r ctrl", rd, 32'h0);
      wb_read(reg_result, rd);
      check_hex("wb_dat_r result", rd, 32'h0);  // empty fifo reads zero

      for (int i = 0; i < n_rand; i++)
         run_op(16'($urandom()), 16'($urandom()), 1'b0);

      wb_write(reg_ctrl, 32'h1);
      run_op(16'hab00, 16'h1200, 1'b1);  // both low halves zero
      run_op(16'h5a80, 16'h3c80, 1'b1);  // top low bits both set
      run_op(16'h0000, 16'h7ce5, 1'b1);  // one operand zero
      for (int i = 0; i < n_rand; i++)
         run_op(16'($urandom()), 16'($urandom()), 1'b1);

      wb_write(reg_ctrl, 32'hffff_fffe);  // only bit 0 matters
      wb_read(reg_ctrl, rd);
      check_hex("wb_dat_r ctrl", rd, 32'h0);
      wb_write(reg_ctrl, 32'h1);
      wb_read(reg_ctrl, rd);
      check_hex("wb_dat_r ctrl", rd, 32'h1);
      wb_cycle(1'b1, reg_ctrl, 32'h0, 4'he, 50, acked, rd);  // byte 0 not selected
      check_true(acked, "ctrl write got no ack within 50 cycles");
      wb_read(reg_ctrl, rd);
      check_hex("wb_dat_r ctrl", rd, 32'h1);

      // mode taken per operation at write time
      wb_write(reg_operands, {16'hc3f1, 16'h9e5b});
      wb_write(reg_ctrl, 32'h0);
      wb_write(reg_operands, {16'hc3f1, 16'h9e5b});
      wait_count(2);
      wb_read(reg_result, rd);
      check_hex("wb_dat_r result", rd, ref_product(16'h9e5b, 16'hc3f1, 1'b1));
      wb_read(reg_result, rd);
      check_hex("wb_dat_r result", rd, ref_product(16'h9e5b, 16'hc3f1, 1'b0));

      // back-pressure with six writes in precise mode
      for (int i = 0; i < 6; i++) begin
         x = 16'($urandom());
         y = 16'($urandom());
         exp_q.push_back(ref_product(x, y, 1'b0));
         if (i < 4) begin
            wb_write(reg_operands, {y, x});
         end else begin
            wb_cycle(1'b1, reg_operands, {y, x}, 4'hf, 20, acked, rd);  // must stall
            check_true(!acked, "operand write acked while fifo and pipeline were full");
            wb_read(reg_status, rd);
            check_hex("wb_dat_r status", rd, 32'h0000_0024);  // count 4 and full
            wb_read(reg_result, rd);  // frees one slot
            check_hex("wb_dat_r result", rd, exp_q.pop_front());
            wb_write(reg_operands, {y, x});
         end
      end
      wait_count(4);
      while (exp_q.size() > 0) begin
         wb_read(reg_result, rd);
         check_hex("wb_dat_r result", rd, exp_q.pop_front());  // write order
      end
      wb_read(reg_status, rd);
      check_hex("wb_dat_r status", rd, 32'h0000_0010);
      wb_read(reg_result, rd);
      check_hex("wb_dat_r result", rd, 32'h0);  // stale head must not leak

      repeat (4) @(posedge clk);
      $display("errors: %0d", errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule
